//--- hw/isu_pkg.sv
package isu_pkg;

    localparam int PREG_NUM = 64;
    localparam int PREG_W   = 6;
    localparam int LREG_W   = 5;
    localparam int XLEN     = 64;
    // one bit above the largest buffer index, used as wrap bit
    localparam int ROBID_W  = 7;

    typedef logic [PREG_W-1:0]  preg_t;
    typedef logic [ROBID_W-1:0] robid_t;

    typedef struct packed {
        logic [5:0]  cx_type;
        logic [10:0] alu_type;
        logic [12:0] muldiv_type;
        logic        is_unsigned;
        logic        is_word;
        logic        is_imm;
        logic        is_load;
        logic        is_store;
        logic [3:0]  ls_size;
    } uop_ctrl_t;

    // renamed instruction from the rename stage
    typedef struct packed {
        logic [XLEN-1:0]   pc;
        logic [31:0]       instr;
        logic [LREG_W-1:0] lrs1;
        logic [LREG_W-1:0] lrs2;
        logic [LREG_W-1:0] lrd;
        preg_t             prs1;
        preg_t             prs2;
        preg_t             prd;
        preg_t             old_prd;
        logic              need_to_wb;
        logic              src1_is_reg;
        logic              src2_is_reg;
        logic [XLEN-1:0]   imm;
        uop_ctrl_t         ctrl;
    } disp_in_t;

    typedef struct packed {
        logic [XLEN-1:0]   pc;
        logic [31:0]       instr;
        logic [LREG_W-1:0] lrd;
        preg_t             prd;
        preg_t             old_prd;
        logic              need_to_wb;
    } rob_entry_t;

    typedef struct packed {
        rob_entry_t entry;
        robid_t     robid;
    } commit_t;

    typedef struct packed {
        robid_t          robid;
        logic [XLEN-1:0] pc;
        preg_t           prs1;
        preg_t           prs2;
        logic            src1_is_reg;
        logic            src2_is_reg;
        logic            src1_ready;
        logic            src2_ready;
        preg_t           prd;
        logic            need_to_wb;
        logic [XLEN-1:0] imm;
        uop_ctrl_t       ctrl;
    } isq_entry_t;

    // operation sent to execution, operands already read
    typedef struct packed {
        robid_t          robid;
        logic [XLEN-1:0] pc;
        preg_t           prd;
        logic            need_to_wb;
        logic [XLEN-1:0] imm;
        uop_ctrl_t       ctrl;
        logic [XLEN-1:0] src1;
        logic [XLEN-1:0] src2;
    } exu_op_t;

    typedef struct packed {
        robid_t          robid;
        preg_t           prd;
        logic            need_to_wb;
        logic [XLEN-1:0] result;
    } wb_t;

endpackage

//--- hw/dispatch.sv
`timescale 1ns/100ps

module dispatch import isu_pkg::*; (
    input  logic       clock,
    input  logic       arst_n,
    input  logic       in_valid,
    output logic       in_ready,
    input  disp_in_t   in_data,
    input  logic       rob_can_enq,
    input  robid_t     rob_robid,
    input  logic       isq_can_enq,
    output logic       rob_enq,
    output rob_entry_t rob_entry,
    output logic       isq_enq,
    output isq_entry_t isq_entry,
    output preg_t      bt_rs1,
    output preg_t      bt_rs2,
    input  logic       bt_rs1_busy,
    input  logic       bt_rs2_busy,
    output logic       bt_alloc,
    output preg_t      bt_alloc_rd
);

    logic live;
    logic accept;

    // comes up one edge after reset release
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            live <= 1'b0;
        end else begin
            live <= 1'b1;
        end
    end

    assign in_ready = live && rob_can_enq && isq_can_enq;
    assign accept   = in_valid && in_ready;
    assign rob_enq  = accept;
    assign isq_enq  = accept;

    // busy lookups for both sources
    assign bt_rs1      = in_data.prs1;
    assign bt_rs2      = in_data.prs2;
    assign bt_alloc    = accept && in_data.need_to_wb;
    assign bt_alloc_rd = in_data.prd;

    always_comb begin
        rob_entry.pc         = in_data.pc;
        rob_entry.instr      = in_data.instr;
        rob_entry.lrd        = in_data.lrd;
        rob_entry.prd        = in_data.prd;
        rob_entry.old_prd    = in_data.old_prd;
        rob_entry.need_to_wb = in_data.need_to_wb;
    end

    always_comb begin
        isq_entry.robid       = rob_robid;
        isq_entry.pc          = in_data.pc;
        isq_entry.prs1        = in_data.prs1;
        isq_entry.prs2        = in_data.prs2;
        isq_entry.src1_is_reg = in_data.src1_is_reg;
        isq_entry.src2_is_reg = in_data.src2_is_reg;
        // immediates and unused sources never wait
        isq_entry.src1_ready  = !in_data.src1_is_reg || !bt_rs1_busy;
        isq_entry.src2_ready  = !in_data.src2_is_reg || !bt_rs2_busy;
        isq_entry.prd         = in_data.prd;
        isq_entry.need_to_wb  = in_data.need_to_wb;
        isq_entry.imm         = in_data.imm;
        isq_entry.ctrl        = in_data.ctrl;
    end

endmodule

//--- hw/busy_table.sv
`timescale 1ns/100ps

module busy_table import isu_pkg::*; (
    input  logic  clock,
    input  logic  arst_n,
    input  preg_t rs1,
    input  preg_t rs2,
    output logic  rs1_busy,
    output logic  rs2_busy,
    input  logic  alloc,
    input  preg_t alloc_rd,
    input  logic  int_wb_valid,
    input  wb_t   int_wb,
    input  logic  mem_wb_valid,
    input  wb_t   mem_wb
);

    logic [PREG_NUM-1:0] busy;
    logic                int_clr;
    logic                mem_clr;

    assign int_clr = int_wb_valid && int_wb.need_to_wb;
    assign mem_clr = mem_wb_valid && mem_wb.need_to_wb;

    // same-cycle writeback counts as already free
    assign rs1_busy = busy[rs1] && (rs1 != '0)
                      && !(int_clr && (int_wb.prd == rs1))
                      && !(mem_clr && (mem_wb.prd == rs1));
    assign rs2_busy = busy[rs2] && (rs2 != '0)
                      && !(int_clr && (int_wb.prd == rs2))
                      && !(mem_clr && (mem_wb.prd == rs2));

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            busy <= '0;
        end else begin
            if (int_clr) begin
                busy[int_wb.prd] <= 1'b0;
            end
            if (mem_clr) begin
                busy[mem_wb.prd] <= 1'b0;
            end
            // a fresh allocation wins over a stale clear
            if (alloc) begin
                busy[alloc_rd] <= 1'b1;
            end
        end
    end

endmodule

//--- hw/rob.sv
`timescale 1ns/100ps

module rob import isu_pkg::*; #(
    parameter int ROB_DEPTH = 16
) (
    input  logic       clock,
    input  logic       arst_n,
    input  logic       enq,
    input  rob_entry_t entry,
    output robid_t     robid,
    output logic       can_enq,
    input  logic       int_wb_valid,
    input  wb_t        int_wb,
    input  logic       mem_wb_valid,
    input  wb_t        mem_wb,
    output logic       commit_valid,
    output commit_t    commit
);

    localparam int IDX_W = $clog2(ROB_DEPTH);

    // top bit of each pointer is the wrap bit
    typedef logic [IDX_W:0] ptr_t;

    rob_entry_t           entries [ROB_DEPTH];
    logic [ROB_DEPTH-1:0] complete;
    ptr_t                 head;
    ptr_t                 tail;
    logic                 full;

    assign full    = (head[IDX_W] != tail[IDX_W])
                     && (head[IDX_W-1:0] == tail[IDX_W-1:0]);
    assign can_enq = !full;
    assign robid   = robid_t'(tail);

    // head retires as soon as its result is back
    assign commit_valid = complete[head[IDX_W-1:0]];
    assign commit.entry = entries[head[IDX_W-1:0]];
    assign commit.robid = robid_t'(head);

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            head     <= '0;
            tail     <= '0;
            complete <= '0;
        end else begin
            if (enq) begin
                tail <= tail + 1'b1;
            end
            if (commit_valid) begin
                head                      <= head + 1'b1;
                complete[head[IDX_W-1:0]] <= 1'b0;
            end
            if (int_wb_valid) begin
                complete[int_wb.robid[IDX_W-1:0]] <= 1'b1;
            end
            if (mem_wb_valid) begin
                complete[mem_wb.robid[IDX_W-1:0]] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (enq) begin
            entries[tail[IDX_W-1:0]] <= entry;
        end
    end

endmodule

//--- hw/int_isq.sv
`timescale 1ns/100ps

module int_isq import isu_pkg::*; #(
    parameter int ISQ_DEPTH = 8
) (
    input  logic            clock,
    input  logic            arst_n,
    input  logic            enq,
    input  isq_entry_t      entry,
    output logic            can_enq,
    input  logic            int_wb_valid,
    input  wb_t             int_wb,
    input  logic            mem_wb_valid,
    input  wb_t             mem_wb,
    output logic            issue_valid,
    input  logic            issue_ready,
    output exu_op_t         issue_op,
    output preg_t           rd_addr1,
    output preg_t           rd_addr2,
    input  logic [XLEN-1:0] rd_data1,
    input  logic [XLEN-1:0] rd_data2
);

    localparam int IDX_W = (ISQ_DEPTH > 1) ? $clog2(ISQ_DEPTH) : 1;

    isq_entry_t           slots [ISQ_DEPTH];
    logic [ISQ_DEPTH-1:0] valid;
    logic [ISQ_DEPTH-1:0] ready_vec;
    logic [IDX_W-1:0]     enq_idx;
    logic [IDX_W-1:0]     sel_idx;
    isq_entry_t           sel;
    logic                 int_wake;
    logic                 mem_wake;
    logic                 fire;

    assign int_wake = int_wb_valid && int_wb.need_to_wb;
    assign mem_wake = mem_wb_valid && mem_wb.need_to_wb;

    always_comb begin
        for (int i = 0; i < ISQ_DEPTH; i++) begin
            ready_vec[i] = valid[i] && slots[i].src1_ready && slots[i].src2_ready;
        end
    end

    // lowest free slot and lowest ready slot
    always_comb begin
        enq_idx = '0;
        sel_idx = '0;
        for (int i = ISQ_DEPTH - 1; i >= 0; i--) begin
            if (!valid[i]) begin
                enq_idx = IDX_W'(i);
            end
            if (ready_vec[i]) begin
                sel_idx = IDX_W'(i);
            end
        end
    end

    assign can_enq     = !(&valid);
    assign issue_valid = |ready_vec;
    assign fire        = issue_valid && issue_ready;
    assign sel         = slots[sel_idx];

    // operand read goes straight to the register file
    assign rd_addr1 = sel.prs1;
    assign rd_addr2 = sel.prs2;

    always_comb begin
        issue_op.robid      = sel.robid;
        issue_op.pc         = sel.pc;
        issue_op.prd        = sel.prd;
        issue_op.need_to_wb = sel.need_to_wb;
        issue_op.imm        = sel.imm;
        issue_op.ctrl       = sel.ctrl;
        issue_op.src1       = sel.src1_is_reg ? rd_data1 : '0;
        issue_op.src2       = sel.src2_is_reg ? rd_data2 : '0;
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            valid <= '0;
        end else begin
            if (fire) begin
                valid[sel_idx] <= 1'b0;
            end
            if (enq) begin
                valid[enq_idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        // wakeup on either writeback port
        for (int i = 0; i < ISQ_DEPTH; i++) begin
            if ((int_wake && slots[i].prs1 == int_wb.prd)
                || (mem_wake && slots[i].prs1 == mem_wb.prd)) begin
                slots[i].src1_ready <= 1'b1;
            end
            if ((int_wake && slots[i].prs2 == int_wb.prd)
                || (mem_wake && slots[i].prs2 == mem_wb.prd)) begin
                slots[i].src2_ready <= 1'b1;
            end
        end
        // new entry already saw this cycle's writeback via busy bypass
        if (enq) begin
            slots[enq_idx] <= entry;
        end
    end

endmodule

//--- hw/pregfile.sv
`timescale 1ns/100ps

module pregfile import isu_pkg::*; (
    input  logic            clock,
    input  logic            arst_n,
    input  logic            wen0,
    input  preg_t           waddr0,
    input  logic [XLEN-1:0] wdata0,
    input  logic            wen1,
    input  preg_t           waddr1,
    input  logic [XLEN-1:0] wdata1,
    input  preg_t           raddr0,
    input  preg_t           raddr1,
    output logic [XLEN-1:0] rdata0,
    output logic [XLEN-1:0] rdata1
);

    logic [XLEN-1:0] regs [PREG_NUM];

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < PREG_NUM; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (wen0) begin
                regs[waddr0] <= wdata0;
            end
            if (wen1) begin
                regs[waddr1] <= wdata1;
            end
        end
    end

    // p0 is hardwired zero
    assign rdata0 = (raddr0 == '0) ? '0 : regs[raddr0];
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];

endmodule

//--- hw/isu_top.sv
`timescale 1ns/100ps

module isu_top import isu_pkg::*; #(
    parameter int ROB_DEPTH = 16,
    parameter int ISQ_DEPTH = 8
) (
    input  logic     clock,
    input  logic     arst_n,
    input  logic     in_valid,
    output logic     in_ready,
    input  disp_in_t in_data,
    input  logic     int_wb_valid,
    input  wb_t      int_wb,
    input  logic     mem_wb_valid,
    input  wb_t      mem_wb,
    output logic     issue_valid,
    input  logic     issue_ready,
    output exu_op_t  issue_op,
    output logic     commit_valid,
    output commit_t  commit
);

    logic            rob_can_enq;
    robid_t          rob_robid;
    logic            isq_can_enq;
    logic            rob_enq;
    rob_entry_t      rob_entry;
    logic            isq_enq;
    isq_entry_t      isq_entry;
    preg_t           bt_rs1;
    preg_t           bt_rs2;
    logic            bt_rs1_busy;
    logic            bt_rs2_busy;
    logic            bt_alloc;
    preg_t           bt_alloc_rd;
    preg_t           rd_addr1;
    preg_t           rd_addr2;
    logic [XLEN-1:0] rd_data1;
    logic [XLEN-1:0] rd_data2;

    dispatch u_dispatch (
        .clock       (clock),
        .arst_n      (arst_n),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .in_data     (in_data),
        .rob_can_enq (rob_can_enq),
        .rob_robid   (rob_robid),
        .isq_can_enq (isq_can_enq),
        .rob_enq     (rob_enq),
        .rob_entry   (rob_entry),
        .isq_enq     (isq_enq),
        .isq_entry   (isq_entry),
        .bt_rs1      (bt_rs1),
        .bt_rs2      (bt_rs2),
        .bt_rs1_busy (bt_rs1_busy),
        .bt_rs2_busy (bt_rs2_busy),
        .bt_alloc    (bt_alloc),
        .bt_alloc_rd (bt_alloc_rd)
    );

    busy_table u_busy_table (
        .clock        (clock),
        .arst_n       (arst_n),
        .rs1          (bt_rs1),
        .rs2          (bt_rs2),
        .rs1_busy     (bt_rs1_busy),
        .rs2_busy     (bt_rs2_busy),
        .alloc        (bt_alloc),
        .alloc_rd     (bt_alloc_rd),
        .int_wb_valid (int_wb_valid),
        .int_wb       (int_wb),
        .mem_wb_valid (mem_wb_valid),
        .mem_wb       (mem_wb)
    );

    rob #(
        .ROB_DEPTH (ROB_DEPTH)
    ) u_rob (
        .clock        (clock),
        .arst_n       (arst_n),
        .enq          (rob_enq),
        .entry        (rob_entry),
        .robid        (rob_robid),
        .can_enq      (rob_can_enq),
        .int_wb_valid (int_wb_valid),
        .int_wb       (int_wb),
        .mem_wb_valid (mem_wb_valid),
        .mem_wb       (mem_wb),
        .commit_valid (commit_valid),
        .commit       (commit)
    );

    int_isq #(
        .ISQ_DEPTH (ISQ_DEPTH)
    ) u_int_isq (
        .clock        (clock),
        .arst_n       (arst_n),
        .enq          (isq_enq),
        .entry        (isq_entry),
        .can_enq      (isq_can_enq),
        .int_wb_valid (int_wb_valid),
        .int_wb       (int_wb),
        .mem_wb_valid (mem_wb_valid),
        .mem_wb       (mem_wb),
        .issue_valid  (issue_valid),
        .issue_ready  (issue_ready),
        .issue_op     (issue_op),
        .rd_addr1     (rd_addr1),
        .rd_addr2     (rd_addr2),
        .rd_data1     (rd_data1),
        .rd_data2     (rd_data2)
    );

    // only results that target a register are written
    pregfile u_pregfile (
        .clock  (clock),
        .arst_n (arst_n),
        .wen0   (int_wb_valid && int_wb.need_to_wb),
        .waddr0 (int_wb.prd),
        .wdata0 (int_wb.result),
        .wen1   (mem_wb_valid && mem_wb.need_to_wb),
        .waddr1 (mem_wb.prd),
        .wdata1 (mem_wb.result),
        .raddr0 (rd_addr1),
        .raddr1 (rd_addr2),
        .rdata0 (rd_data1),
        .rdata1 (rd_data2)
    );

endmodule

//--- sim/isu_assert.sv
`timescale 1ns/100ps

module isu_assert import isu_pkg::*; #(
    parameter int ROB_DEPTH = 16
) (
    input logic    clock,
    input logic    arst_n,
    input logic    issue_valid,
    input logic    commit_valid,
    input commit_t commit
);

    robid_t last_id;
    logic   seen;

    // id of the previous commit
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            last_id <= '0;
            seen    <= 1'b0;
        end else if (commit_valid) begin
            last_id <= commit.robid;
            seen    <= 1'b1;
        end
    end

    quiet_in_reset: assert property (@(posedge clock)
        !arst_n |-> !issue_valid && !commit_valid)
        else $error("issue_valid or commit_valid high during reset");

    // ids wrap at twice the buffer depth
    commit_in_order: assert property (@(posedge clock) disable iff (!arst_n)
        commit_valid && seen |-> commit.robid == robid_t'((int'(last_id) + 1) % (2 * ROB_DEPTH)))
        else $error("commit id does not follow the previous commit id");

endmodule

bind isu_top isu_assert #(
    .ROB_DEPTH (ROB_DEPTH)
) u_isu_assert (
    .clock        (clock),
    .arst_n       (arst_n),
    .issue_valid  (issue_valid),
    .commit_valid (commit_valid),
    .commit       (commit)
);

//--- sim/isu_tb.sv
`timescale 1ns/100ps

module isu_tb import isu_pkg::*; ();

    localparam int ROB_DEPTH  = 16;
    localparam int ISQ_DEPTH  = 8;
    localparam int ID_NUM     = 2 * ROB_DEPTH;
    localparam int N_INSTR    = 300;
    localparam int MAX_CYCLES = N_INSTR * 20 + 2000;

    logic     clock;
    logic     arst_n;
    logic     in_valid;
    logic     in_ready;
    disp_in_t in_data;
    logic     int_wb_valid;
    wb_t      int_wb;
    logic     mem_wb_valid;
    wb_t      mem_wb;
    logic     issue_valid;
    logic     issue_ready;
    exu_op_t  issue_op;
    logic     commit_valid;
    commit_t  commit;

    // register and rename model
    logic [XLEN-1:0] reg_val [PREG_NUM];
    bit              pending [PREG_NUM];
    preg_t           rename_map [32];
    preg_t           free_q [$];
    // per-id view of what was dispatched
    disp_in_t        by_id [ID_NUM];
    bit              in_flight [ID_NUM];
    bit              issued [ID_NUM];
    bit              wb_done [ID_NUM];
    robid_t          order_q [$];
    robid_t          next_id;
    // execution pipe, one due cycle per issued op
    robid_t          pipe_id [$];
    int              pipe_due [$];

    int cycle;
    int accepted;
    int issues;
    int commits;
    int stall_state;
    int stall_left;
    bit taken;
    int err_issue;
    int err_commit;
    int err_count;
    int err_other;

    isu_top #(
        .ROB_DEPTH (ROB_DEPTH),
        .ISQ_DEPTH (ISQ_DEPTH)
    ) dut0 (
        .clock        (clock),
        .arst_n       (arst_n),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .in_data      (in_data),
        .int_wb_valid (int_wb_valid),
        .int_wb       (int_wb),
        .mem_wb_valid (mem_wb_valid),
        .mem_wb       (mem_wb),
        .issue_valid  (issue_valid),
        .issue_ready  (issue_ready),
        .issue_op     (issue_op),
        .commit_valid (commit_valid),
        .commit       (commit)
    );

    always #10 clock = ~clock;

    task automatic check_issue(input exu_op_t got, input exu_op_t exp);
        if (got !== exp) begin
            err_issue++;
            $display("FAIL issue_op: got %h expected %h", got, exp);
        end
    endtask

    task automatic check_commit(input commit_t got, input commit_t exp);
        if (got !== exp) begin
            err_commit++;
            $display("FAIL commit: got %h expected %h", got, exp);
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            err_count++;
            $display("FAIL %s: got %h expected %h", name, got, exp);
        end
    endtask

    // operands come from the last value written, zero for immediates
    function automatic exu_op_t expected_issue(disp_in_t d, robid_t id);
        exu_op_t e;
        e.robid      = id;
        e.pc         = d.pc;
        e.prd        = d.prd;
        e.need_to_wb = d.need_to_wb;
        e.imm        = d.imm;
        e.ctrl       = d.ctrl;
        e.src1       = d.src1_is_reg ? reg_val[d.prs1] : '0;
        e.src2       = d.src2_is_reg ? reg_val[d.prs2] : '0;
        return e;
    endfunction

    function automatic commit_t expected_commit(disp_in_t d, robid_t id);
        commit_t e;
        e.entry.pc         = d.pc;
        e.entry.instr      = d.instr;
        e.entry.lrd        = d.lrd;
        e.entry.prd        = d.prd;
        e.entry.old_prd    = d.old_prd;
        e.entry.need_to_wb = d.need_to_wb;
        e.robid            = id;
        return e;
    endfunction

    function automatic wb_t make_wb(robid_t id);
        wb_t w;
        w.robid      = id;
        w.prd        = by_id[id].prd;
        w.need_to_wb = by_id[id].need_to_wb;
        w.result     = {$urandom, $urandom};
        return w;
    endfunction

    task automatic make_instr(output disp_in_t d);
        int kind;
        kind          = $urandom % 10;
        d             = '0;
        d.pc          = {$urandom, $urandom};
        d.instr       = $urandom;
        d.lrs1        = LREG_W'($urandom);
        d.lrs2        = LREG_W'($urandom);
        d.lrd         = LREG_W'(1 + $urandom % 31);
        d.src1_is_reg = ($urandom % 4) != 0;
        d.src2_is_reg = ($urandom % 4) != 0;
        // register sources follow the current rename map
        d.prs1        = d.src1_is_reg ? rename_map[d.lrs1] : preg_t'($urandom);
        d.prs2        = d.src2_is_reg ? rename_map[d.lrs2] : preg_t'($urandom);
        d.imm         = {$urandom, $urandom};
        d.ctrl        = uop_ctrl_t'(39'({$urandom, $urandom}));
        d.ctrl.is_load  = (kind < 2);
        d.ctrl.is_store = (kind == 2);
        d.need_to_wb    = (kind != 2);
        if (d.need_to_wb) begin
            d.prd     = free_q[0];
            d.old_prd = rename_map[d.lrd];
        end
    endtask

    task automatic drop_pipe(input int idx);
        pipe_id.delete(idx);
        pipe_due.delete(idx);
    endtask

    task automatic drive_inputs();
        int       int_idx;
        int       mem_idx;
        disp_in_t d;
        int_idx = -1;
        mem_idx = -1;
        // one long stall once a third of the stream is in
        if (stall_state == 0 && accepted >= N_INSTR / 3) begin
            stall_state = 1;
            stall_left  = 40;
        end
        if (stall_state == 1 && stall_left == 0) begin
            check_count("in_ready", in_ready, 0);
            // oldest waiting entry has all its producers written back by now
            check_count("issue_valid", issue_valid, 1);
            if (accepted - commits < ROB_DEPTH) begin
                check_count("waiting", accepted - issues, ISQ_DEPTH);
            end
            stall_state = 2;
        end
        if (stall_state == 1) begin
            issue_ready = 1'b0;
            stall_left--;
        end else begin
            issue_ready = ($urandom % 4) != 0;
        end

        // hold the offered instruction until it is taken
        if (!in_valid || taken) begin
            in_valid = 1'b0;
            if (accepted < N_INSTR && free_q.size() > 0
                && (stall_state == 1 || ($urandom % 5) != 0)) begin
                make_instr(d);
                in_data  = d;
                in_valid = 1'b1;
            end
        end
        taken = 1'b0;

        int_wb_valid = 1'b0;
        mem_wb_valid = 1'b0;
        foreach (pipe_id[i]) begin
            if (pipe_due[i] <= cycle) begin
                if (by_id[pipe_id[i]].ctrl.is_load) begin
                    if (mem_idx < 0) begin
                        mem_idx = i;
                    end
                end else if (int_idx < 0) begin
                    int_idx = i;
                end
            end
        end
        if (mem_idx >= 0) begin
            mem_wb       = make_wb(pipe_id[mem_idx]);
            mem_wb_valid = 1'b1;
        end
        if (int_idx >= 0) begin
            int_wb       = make_wb(pipe_id[int_idx]);
            int_wb_valid = 1'b1;
        end
        // higher index goes first so the other stays valid
        if (mem_idx > int_idx) begin
            drop_pipe(mem_idx);
            if (int_idx >= 0) begin
                drop_pipe(int_idx);
            end
        end else if (int_idx >= 0) begin
            drop_pipe(int_idx);
            if (mem_idx >= 0) begin
                drop_pipe(mem_idx);
            end
        end
    endtask

    task automatic record_issue();
        robid_t   id;
        disp_in_t d;
        id = issue_op.robid;
        if (!in_flight[id] || issued[id]) begin
            err_other++;
            $display("issue of robid %0d, which is not waiting in the queue", id);
        end else begin
            d = by_id[id];
            if ((d.src1_is_reg && pending[d.prs1]) || (d.src2_is_reg && pending[d.prs2])) begin
                err_other++;
                $display("robid %0d issued before its sources were written back", id);
            end
            check_issue(issue_op, expected_issue(d, id));
            issued[id] = 1'b1;
            issues++;
            pipe_id.push_back(id);
            pipe_due.push_back(cycle + 1 + int'($urandom % 6));
        end
    endtask

    task automatic record_commit();
        robid_t   id;
        disp_in_t d;
        if (order_q.size() == 0) begin
            err_other++;
            $display("commit seen with no instruction in flight");
        end else begin
            id = order_q.pop_front();
            d  = by_id[id];
            if (!wb_done[id]) begin
                err_other++;
                $display("robid %0d committed before its writeback", id);
            end
            check_commit(commit, expected_commit(d, id));
            // the overwritten mapping is now dead
            if (d.need_to_wb && d.old_prd != '0) begin
                free_q.push_back(d.old_prd);
            end
            in_flight[id] = 1'b0;
            commits++;
        end
    endtask

    task automatic record_dispatch();
        by_id[next_id]     = in_data;
        in_flight[next_id] = 1'b1;
        issued[next_id]    = 1'b0;
        wb_done[next_id]   = 1'b0;
        order_q.push_back(next_id);
        if (in_data.need_to_wb) begin
            pending[in_data.prd]    = 1'b1;
            rename_map[in_data.lrd] = in_data.prd;
            void'(free_q.pop_front());
        end
        next_id = robid_t'((int'(next_id) + 1) % ID_NUM);
        accepted++;
        taken = 1'b1;
    endtask

    task automatic apply_wb(input wb_t w);
        if (w.need_to_wb) begin
            reg_val[w.prd] = w.result;
            pending[w.prd] = 1'b0;
        end
        wb_done[w.robid] = 1'b1;
    endtask

    // handshakes are sampled before the edge updates any state
    always @(posedge clock) begin
        cycle++;
        if (cycle >= MAX_CYCLES) begin
            $display("timeout: only %0d of %0d committed after %0d cycles",
                     commits, N_INSTR, cycle);
            $display("test failed");
            $finish;
        end else if (arst_n) begin
            if (issue_valid && issue_ready) begin
                record_issue();
            end
            if (commit_valid) begin
                record_commit();
            end
            if (in_valid && in_ready) begin
                record_dispatch();
            end
            if (int_wb_valid) begin
                apply_wb(int_wb);
            end
            if (mem_wb_valid) begin
                apply_wb(mem_wb);
            end
        end
    end

    initial begin
        clock        = 1'b0;
        arst_n       = 1'b1;
        in_valid     = 1'b0;
        in_data      = '0;
        int_wb_valid = 1'b0;
        int_wb       = '0;
        mem_wb_valid = 1'b0;
        mem_wb       = '0;
        issue_ready  = 1'b0;
        next_id      = '0;
        void'($urandom(32'h5d4f));
        for (int p = 0; p < PREG_NUM; p++) begin
            reg_val[p] = '0;
        end
        for (int p = 1; p < PREG_NUM; p++) begin
            free_q.push_back(preg_t'(p));
        end
        for (int l = 0; l < 32; l++) begin
            rename_map[l] = '0;
        end
        #1 arst_n = 1'b0;
        repeat (5) @(posedge clock);
        @(negedge clock);
        arst_n = 1'b1;
        while (commits < N_INSTR) begin
            @(negedge clock);
            drive_inputs();
        end
        // nothing is left to issue or commit
        check_count("issue_valid", issue_valid, 0);
        check_count("commit_valid", commit_valid, 0);
        check_count("issues", issues, N_INSTR);
        check_count("pipe_left", pipe_id.size(), 0);
        $display("errors: %0d issue, %0d commit, %0d count, %0d other; %0d committed",
                 err_issue, err_commit, err_count, err_other, commits);
        if (err_issue + err_commit + err_count + err_other == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- src.f
hw/isu_pkg.sv
hw/dispatch.sv
hw/busy_table.sv
hw/rob.sv
hw/int_isq.sv
hw/pregfile.sv
hw/isu_top.sv
sim/isu_assert.sv
sim/isu_tb.sv

//--- Bender.yml
package:
  name: isu

sources:
  - hw/isu_pkg.sv
  - hw/dispatch.sv
  - hw/busy_table.sv
  - hw/rob.sv
  - hw/int_isq.sv
  - hw/pregfile.sv
  - hw/isu_top.sv
  - target: simulation
    files:
      - sim/isu_assert.sv
      - sim/isu_tb.sv
